// ==== hw/game_geom_pkg.sv ====
`default_nettype none

package game_geom_pkg;

    // screen coordinate, wide enough for the blanking lines
    typedef logic [9:0] coord_t;

    ////////////////////
    // raster
    ////////////////////

    localparam int screen_w = 640;
    localparam int screen_h = 480;
    // pixel 0 of this line marks one frame
    localparam int frame_line = 481;

    ////////////////////
    // brick wall
    ////////////////////

    localparam int brick_w = 40;
    localparam int brick_h = 30;
    localparam int brick_cols = 16;
    localparam int brick_rows = 6;
    // one bit per brick, row * 16 + col
    typedef logic [brick_rows*brick_cols-1:0] brick_map_t;

    ////////////////////
    // ball and paddle
    ////////////////////

    localparam int ball_size = 8;
    // rightmost left edge that keeps the ball on screen
    localparam int ball_max_x = screen_w - ball_size;
    localparam int ball_start_x = 316;
    localparam int ball_start_y = 445;

    // paddle band, both lines inclusive
    localparam int paddle_top = 453;
    localparam int paddle_bottom = 457;

endpackage

`default_nettype wire

// ==== hw/game_ctrl_pkg.sv ====
`default_nettype none

package game_ctrl_pkg;

    ////////////////////
    // ball direction
    ////////////////////

    // idle waits for start, stopped is the end of the game
    typedef enum logic [2:0] {
        idle,
        up_left,
        up_right,
        down_right,
        down_left,
        stopped
    } ball_dir_t;

    ////////////////////
    // colours
    ////////////////////

    // one bit per gun, r g b
    typedef logic [2:0] rgb_t;

    localparam rgb_t colour_black = 3'b000;
    // brick tints cycle with the brick index
    localparam rgb_t brick_blue = 3'b001;
    localparam rgb_t brick_red = 3'b100;
    localparam rgb_t brick_green = 3'b010;
    localparam rgb_t paddle_colour = 3'b110;
    localparam rgb_t ball_colour = 3'b100;

endpackage

`default_nettype wire

// ==== hw/ball_if.sv ====
`default_nettype none

interface ball_if;
    import game_geom_pkg::*;

    // top-left corner of the ball box
    coord_t ball_x;
    coord_t ball_y;
    // same corner one step further along the direction
    coord_t next_x;
    coord_t next_y;

    // motion block owns the ball
    modport source (output ball_x, ball_y, next_x, next_y);
    // bricks and pixel colour only look at it
    modport sink (input ball_x, ball_y, next_x, next_y);

endinterface

`default_nettype wire

// ==== hw/playfield_scan.sv ====
`default_nettype none

module playfield_scan (
    input  wire                    clk,
    input  wire                    reset,
    input  wire game_geom_pkg::coord_t pix_x,
    input  wire game_geom_pkg::coord_t pix_y,
    output game_geom_pkg::coord_t  pix_x_q,
    output game_geom_pkg::coord_t  pix_y_q,
    output logic                   frame_tick
);
    import game_geom_pkg::*;

    // one register stage on the scan position
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pix_x_q <= '0;
            pix_y_q <= '0;
        end else begin
            pix_x_q <= pix_x;
            pix_y_q <= pix_y;
        end
    end

    // strobe for the first pixel of the line below the visible area
    // high for exactly one cycle per frame
    assign frame_tick = (pix_y_q == coord_t'(frame_line)) && (pix_x_q == '0);

endmodule

`default_nettype wire

// ==== hw/paddle_ctrl.sv ====
`default_nettype none

module paddle_ctrl #(
    parameter int PADDLE_WIDTH = 80,
    parameter int PADDLE_STEP  = 2
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire [1:0]             btn,
    input  wire                   frame_tick,
    output game_geom_pkg::coord_t paddle_x
);
    import game_geom_pkg::*;

    // paddle centred on the screen
    localparam int home_x = screen_w / 2 - PADDLE_WIDTH / 2;

    logic can_right;
    logic can_left;

    // right edge after the step still on screen
    assign can_right = int'(paddle_x) + PADDLE_WIDTH + PADDLE_STEP <= screen_w;
    // left edge has room for one step
    assign can_left = int'(paddle_x) >= PADDLE_STEP;

    ////////////////////
    // paddle position
    ////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            paddle_x <= coord_t'(home_x);
        end else if (frame_tick) begin
            // right button wins when both are held
            if (btn[0] && can_right) begin
                paddle_x <= paddle_x + coord_t'(PADDLE_STEP);
            end else if (btn[1] && can_left) begin
                paddle_x <= paddle_x - coord_t'(PADDLE_STEP);
            end
        end
    end

    // whole paddle stays inside the visible width
    a_paddle_on_screen: assert property (
        @(posedge clk) disable iff (!reset)
        int'(paddle_x) + PADDLE_WIDTH <= screen_w
    ) else $error("paddle outside the screen at x=%0d", paddle_x);

endmodule

`default_nettype wire

// ==== hw/ball_motion.sv ====
`default_nettype none

module ball_motion #(
    parameter int PADDLE_WIDTH = 80
) (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        start,
    input  wire                        frame_tick,
    input  wire                        brick_hit,
    input  wire game_geom_pkg::coord_t paddle_x,
    ball_if.source                     ball
);
    import game_geom_pkg::*;
    import game_ctrl_pkg::*;

    ball_dir_t dir;
    ball_dir_t dir_bounce;
    coord_t pos_x;
    coord_t pos_y;
    coord_t next_x;
    coord_t next_y;
    logic mv_left;
    logic mv_up;
    logic mv_down;
    logic hit_side;
    logic hit_vert;
    logic on_paddle;
    logic fell_out;

    assign ball.ball_x = pos_x;
    assign ball.ball_y = pos_y;
    assign ball.next_x = next_x;
    assign ball.next_y = next_y;

    ////////////////////
    // one step ahead
    ////////////////////

    always_comb begin
        next_x = pos_x;
        next_y = pos_y;
        case (dir)
            up_left: begin
                next_x = pos_x - 1'b1;
                next_y = pos_y - 1'b1;
            end
            up_right: begin
                next_x = pos_x + 1'b1;
                next_y = pos_y - 1'b1;
            end
            down_right: begin
                next_x = pos_x + 1'b1;
                next_y = pos_y + 1'b1;
            end
            down_left: begin
                next_x = pos_x - 1'b1;
                next_y = pos_y + 1'b1;
            end
            // idle and stopped hold still
            default: begin
            end
        endcase
    end

    assign mv_left = (dir == up_left) || (dir == down_left);
    assign mv_up = (dir == up_left) || (dir == up_right);
    assign mv_down = (dir == down_left) || (dir == down_right);

    // next box against the paddle rows and span
    assign on_paddle = (int'(next_y) + ball_size - 1 >= paddle_top)
                    && (int'(next_y) <= paddle_bottom)
                    && (int'(next_x) + ball_size - 1 >= int'(paddle_x))
                    && (int'(next_x) <= int'(paddle_x) + PADDLE_WIDTH - 1);

    // side walls
    assign hit_side = (mv_left && next_x == '0)
                   || (!mv_left && int'(next_x) >= ball_max_x);
    // ceiling, any brick, or paddle on the way down
    assign hit_vert = (mv_up && next_y == '0) || brick_hit || (mv_down && on_paddle);
    // past the bottom of the screen
    assign fell_out = int'(next_y) >= screen_h;

    ////////////////////
    // bounce
    ////////////////////

    always_comb begin
        logic go_left;
        logic go_up;
        go_left = mv_left ^ hit_side;
        go_up = mv_up ^ hit_vert;
        case ({go_up, go_left})
            2'b11: dir_bounce = up_left;
            2'b10: dir_bounce = up_right;
            2'b01: dir_bounce = down_left;
            default: dir_bounce = down_right;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pos_x <= coord_t'(ball_start_x);
            pos_y <= coord_t'(ball_start_y);
            dir <= idle;
        end else if (frame_tick) begin
            case (dir)
                idle: begin
                    // launch towards the wall
                    if (start) begin
                        dir <= up_left;
                    end
                end
                // frozen until reset
                stopped: begin
                end
                default: begin
                    pos_x <= next_x;
                    pos_y <= next_y;
                    dir <= fell_out ? stopped : dir_bounce;
                end
            endcase
        end
    end

    // launch needs a tick with start held
    a_launch_on_start: assert property (
        @(posedge clk) disable iff (!reset)
        (dir == idle && !(frame_tick && start)) |=> (dir == idle)
    ) else $error("ball left idle without start");

    // end state is final
    a_stopped_final: assert property (
        @(posedge clk) disable iff (!reset)
        (dir == stopped) |=> (dir == stopped)
    ) else $error("ball left the stopped state");

endmodule

`default_nettype wire

// ==== hw/brick_field.sv ====
`default_nettype none

module brick_field (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        frame_tick,
    ball_if.sink                       ball,
    input  wire game_geom_pkg::coord_t pix_x_q,
    input  wire game_geom_pkg::coord_t pix_y_q,
    output logic                       brick_hit,
    output logic                       brick_on,
    output logic [6:0]                 brick_index
);
    import game_geom_pkg::*;

    brick_map_t brick_map;
    brick_map_t hit_map;
    logic [2:0] row_idx;
    logic [3:0] col_idx;
    logic row_ok;
    logic col_ok;

    ////////////////////
    // collision
    ////////////////////

    // next ball box against every brick still standing
    always_comb begin
        int box_l;
        int box_t;
        box_l = int'(ball.next_x);
        box_t = int'(ball.next_y);
        for (int r = 0; r < brick_rows; r++) begin
            for (int c = 0; c < brick_cols; c++) begin
                hit_map[r*brick_cols + c] = brick_map[r*brick_cols + c]
                    && (box_l <= c*brick_w + brick_w - 1)
                    && (box_l + ball_size - 1 >= c*brick_w)
                    && (box_t <= r*brick_h + brick_h - 1)
                    && (box_t + ball_size - 1 >= r*brick_h);
            end
        end
    end

    assign brick_hit = |hit_map;

    // full wall after reset, hit bricks go on the frame tick
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            brick_map <= '1;
        end else if (frame_tick) begin
            brick_map <= brick_map & ~hit_map;
        end
    end

    ////////////////////
    // pixel lookup
    ////////////////////

    // cell under the registered pixel
    always_comb begin
        row_idx = '0;
        row_ok = 1'b0;
        col_idx = '0;
        col_ok = 1'b0;
        for (int r = 0; r < brick_rows; r++) begin
            if (int'(pix_y_q) >= r*brick_h && int'(pix_y_q) < (r + 1)*brick_h) begin
                row_idx = 3'(r);
                row_ok = 1'b1;
            end
        end
        for (int c = 0; c < brick_cols; c++) begin
            if (int'(pix_x_q) >= c*brick_w && int'(pix_x_q) < (c + 1)*brick_w) begin
                col_idx = 4'(c);
                col_ok = 1'b1;
            end
        end
    end

    // sixteen columns, so row * 16 + col is a plain concatenation
    assign brick_index = {row_idx, col_idx};
    assign brick_on = row_ok && col_ok && brick_map[brick_index];

    // wall only changes on a frame
    a_map_on_tick: assert property (
        @(posedge clk) disable iff (!reset)
        !frame_tick |=> $stable(brick_map)
    ) else $error("brick map changed outside a frame tick");

endmodule

`default_nettype wire

// ==== hw/pixel_mixer.sv ====
`default_nettype none

module pixel_mixer #(
    parameter int PADDLE_WIDTH = 80
) (
    input  wire game_geom_pkg::coord_t pix_x_q,
    input  wire game_geom_pkg::coord_t pix_y_q,
    ball_if.sink                       ball,
    input  wire game_geom_pkg::coord_t paddle_x,
    input  wire                        brick_on,
    input  wire [6:0]                  brick_index,
    output logic                       graph_on,
    output game_ctrl_pkg::rgb_t        graph_rgb
);
    import game_geom_pkg::*;
    import game_ctrl_pkg::*;

    coord_t rel_x;
    coord_t rel_y;
    logic [7:0] rom_data;
    logic sq_ball_on;
    logic ball_on;
    logic paddle_on;
    logic [1:0] tint;

    ////////////////////
    // round ball
    ////////////////////

    // pixel offset inside the ball box
    assign rel_x = pix_x_q - ball.ball_x;
    assign rel_y = pix_y_q - ball.ball_y;

    // rounded corners, top half mirrored below
    always_comb begin
        case (rel_y[2:0])
            3'd0, 3'd7: rom_data = 8'b0011_1100;
            default: rom_data = 8'b0111_1110;
        endcase
    end

    assign sq_ball_on = (pix_x_q >= ball.ball_x)
                     && (int'(pix_x_q) <= int'(ball.ball_x) + ball_size - 1)
                     && (pix_y_q >= ball.ball_y)
                     && (int'(pix_y_q) <= int'(ball.ball_y) + ball_size - 1);
    assign ball_on = sq_ball_on && rom_data[rel_x[2:0]];

    // paddle band
    assign paddle_on = (int'(pix_y_q) >= paddle_top) && (int'(pix_y_q) <= paddle_bottom)
                    && (pix_x_q >= paddle_x)
                    && (int'(pix_x_q) <= int'(paddle_x) + PADDLE_WIDTH - 1);

    ////////////////////
    // colour
    ////////////////////

    assign tint = 2'(brick_index % 3);
    assign graph_on = brick_on || paddle_on || ball_on;

    // bricks over paddle over ball
    always_comb begin
        graph_rgb = colour_black;
        if (brick_on) begin
            case (tint)
                2'd0: graph_rgb = brick_blue;
                2'd1: graph_rgb = brick_red;
                default: graph_rgb = brick_green;
            endcase
        end else if (paddle_on) begin
            graph_rgb = paddle_colour;
        end else if (ball_on) begin
            graph_rgb = ball_colour;
        end
    end

endmodule

`default_nettype wire

// ==== hw/breakout_top.sv ====
`default_nettype none

module breakout_top #(
    parameter int PADDLE_WIDTH = 80,
    parameter int PADDLE_STEP  = 2
) (
    input  wire                        clk,
    input  wire                        reset,
    // bit 0 right, bit 1 left
    input  wire [1:0]                  btn,
    input  wire                        start,
    input  wire game_geom_pkg::coord_t pix_x,
    input  wire game_geom_pkg::coord_t pix_y,
    output logic                       graph_on,
    output game_ctrl_pkg::rgb_t        graph_rgb
);
    import game_geom_pkg::*;

    coord_t pix_x_q;
    coord_t pix_y_q;
    coord_t paddle_x;
    logic frame_tick;
    logic brick_hit;
    logic brick_on;
    logic [6:0] brick_index;

    // ball position and lookahead
    ball_if ball_bus ();

    playfield_scan u_scan (
        .clk        (clk),
        .reset      (reset),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_x_q    (pix_x_q),
        .pix_y_q    (pix_y_q),
        .frame_tick (frame_tick)
    );

    paddle_ctrl #(
        .PADDLE_WIDTH (PADDLE_WIDTH),
        .PADDLE_STEP  (PADDLE_STEP)
    ) u_paddle (
        .clk        (clk),
        .reset      (reset),
        .btn        (btn),
        .frame_tick (frame_tick),
        .paddle_x   (paddle_x)
    );

    ball_motion #(
        .PADDLE_WIDTH (PADDLE_WIDTH)
    ) u_ball (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .frame_tick (frame_tick),
        .brick_hit  (brick_hit),
        .paddle_x   (paddle_x),
        .ball       (ball_bus.source)
    );

    brick_field u_bricks (
        .clk         (clk),
        .reset       (reset),
        .frame_tick  (frame_tick),
        .ball        (ball_bus.sink),
        .pix_x_q     (pix_x_q),
        .pix_y_q     (pix_y_q),
        .brick_hit   (brick_hit),
        .brick_on    (brick_on),
        .brick_index (brick_index)
    );

    pixel_mixer #(
        .PADDLE_WIDTH (PADDLE_WIDTH)
    ) u_mixer (
        .pix_x_q     (pix_x_q),
        .pix_y_q     (pix_y_q),
        .ball        (ball_bus.sink),
        .paddle_x    (paddle_x),
        .brick_on    (brick_on),
        .brick_index (brick_index),
        .graph_on    (graph_on),
        .graph_rgb   (graph_rgb)
    );

endmodule

`default_nettype wire

// ==== bench/game_model.svh ====
`ifndef GAME_MODEL_SVH
`define GAME_MODEL_SVH

////////////////////
// model state
////////////////////

localparam int phase_idle = 0;
localparam int phase_moving = 1;
localparam int phase_stopped = 2;

int m_pad;
int m_bx;
int m_by;
int m_dx;
int m_dy;
int m_phase;
// one bit per brick, row * 16 + col
logic [95:0] m_bricks;

task automatic reset_model();
    // paddle centred on the 640 wide screen
    m_pad = 320 - PADDLE_WIDTH / 2;
    m_bx = 316;
    m_by = 445;
    m_dx = 0;
    m_dy = 0;
    m_phase = phase_idle;
    m_bricks = '1;
endtask

// right wins, each move only if it keeps the paddle on screen
function automatic int stepped_paddle(input int px, input logic [1:0] b);
    if (b[0] && px + PADDLE_WIDTH + PADDLE_STEP <= 640) begin
        return px + PADDLE_STEP;
    end else if (b[1] && px >= PADDLE_STEP) begin
        return px - PADDLE_STEP;
    end
    return px;
endfunction

// standing bricks touched by an 8x8 box at (bx, by)
function automatic logic [95:0] bricks_under(input int bx, input int by, input logic [95:0] map);
    logic [95:0] hit;
    hit = '0;
    for (int r = 0; r < 6; r++) begin
        for (int c = 0; c < 16; c++) begin
            if (map[r*16 + c] && bx <= c*40 + 39 && bx + 7 >= c*40
                && by <= r*30 + 29 && by + 7 >= r*30) begin
                hit[r*16 + c] = 1'b1;
            end
        end
    end
    return hit;
endfunction

// box against the paddle band, lines 453 to 457
function automatic logic over_paddle(input int bx, input int by, input int px);
    return by + 7 >= 453 && by <= 457 && bx + 7 >= px && bx <= px + PADDLE_WIDTH - 1;
endfunction

// one frame, ball decided on the old paddle position
task automatic advance_model(input logic [1:0] b, input logic st);
    int nx;
    int ny;
    logic [95:0] hit;
    logic flip_x;
    logic flip_y;
    if (m_phase == phase_idle) begin
        if (st) begin
            m_phase = phase_moving;
            m_dx = -1;
            m_dy = -1;
        end
    end else if (m_phase == phase_moving) begin
        nx = m_bx + m_dx;
        ny = m_by + m_dy;
        hit = bricks_under(nx, ny, m_bricks);
        flip_x = (m_dx < 0 && nx <= 0) || (m_dx > 0 && nx >= 632);
        flip_y = (m_dy < 0 && ny <= 0) || (|hit) || (m_dy > 0 && over_paddle(nx, ny, m_pad));
        m_bricks = m_bricks & ~hit;
        m_bx = nx;
        m_by = ny;
        if (ny >= 480) begin
            m_phase = phase_stopped;
        end else begin
            m_dx = flip_x ? -m_dx : m_dx;
            m_dy = flip_y ? -m_dy : m_dy;
        end
    end
    m_pad = stepped_paddle(m_pad, b);
endtask

// {graph_on, rgb} for one pixel, bricks over paddle over ball
function automatic logic [3:0] expected_pixel(input int x, input int y);
    int idx;
    int rx;
    int ry;
    int cut;
    if (x < 640 && y < 180) begin
        idx = (y / 30) * 16 + x / 40;
        if (m_bricks[idx]) begin
            case (idx % 3)
                0: return 4'b1001;
                1: return 4'b1100;
                default: return 4'b1010;
            endcase
        end
    end
    if (y >= 453 && y <= 457 && x >= m_pad && x < m_pad + PADDLE_WIDTH) begin
        return 4'b1110;
    end
    rx = x - m_bx;
    ry = y - m_by;
    if (rx >= 0 && rx < 8 && ry >= 0 && ry < 8) begin
        // two pixels off the outer rows, one elsewhere
        cut = (ry == 0 || ry == 7) ? 2 : 1;
        if (rx >= cut && rx <= 7 - cut) begin
            return 4'b1100;
        end
    end
    return 4'b0000;
endfunction

`endif

// ==== bench/breakout_tb.sv ====
`default_nettype none

module breakout_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PADDLE_WIDTH = 80;
    localparam int PADDLE_STEP = 2;
    localparam int frame_line = 481;
    // parking pixel between ticks and probes, off screen
    localparam int idle_x = 700;
    localparam int idle_y = 500;
    localparam int wait_limit = 8;
    localparam int num_steps = 38;

    // probe position modes
    localparam int abs_probe = 0;
    localparam int ball_probe = 1;
    localparam int paddle_probe = 2;

    typedef struct {
        string name;
        logic [1:0] btn;
        logic start;
        int ticks;
        int mode;
        int px;
        int py;
        logic from_model;
        logic [3:0] want;
    } step_t;

    logic clk;
    logic reset;
    logic [1:0] btn;
    logic start;
    logic [9:0] pix_x;
    logic [9:0] pix_y;
    logic graph_on;
    logic [2:0] graph_rgb;

    int errors;
    int checks;
    int timeouts;
    step_t steps [num_steps];

    `include "game_model.svh"

    breakout_top #(
        .PADDLE_WIDTH (PADDLE_WIDTH),
        .PADDLE_STEP  (PADDLE_STEP)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .btn       (btn),
        .start     (start),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .graph_on  (graph_on),
        .graph_rgb (graph_rgb)
    );

    // 40 ns period
    always #20 clk = ~clk;

    ////////////////////
    // stimulus table
    ////////////////////

    task automatic load_steps();
        // after reset
        steps[0] = '{"reset brick 0", 2'b00, 1'b0, 0, abs_probe, 5, 5, 1'b0, 4'b1001};
        steps[1] = '{"reset brick 1", 2'b00, 1'b0, 0, abs_probe, 45, 5, 1'b0, 4'b1100};
        steps[2] = '{"reset brick 17", 2'b00, 1'b0, 0, abs_probe, 45, 35, 1'b0, 4'b1010};
        steps[3] = '{"reset brick 95", 2'b00, 1'b0, 0, abs_probe, 635, 175, 1'b0, 4'b1010};
        steps[4] = '{"reset brick 37", 2'b00, 1'b0, 0, abs_probe, 205, 65, 1'b1, 4'b0000};
        steps[5] = '{"paddle left end", 2'b00, 1'b0, 0, abs_probe, 280, 455, 1'b0, 4'b1110};
        steps[6] = '{"paddle right end", 2'b00, 1'b0, 0, abs_probe, 359, 455, 1'b0, 4'b1110};
        steps[7] = '{"left of paddle", 2'b00, 1'b0, 0, abs_probe, 279, 455, 1'b0, 4'b0000};
        steps[8] = '{"right of paddle", 2'b00, 1'b0, 0, abs_probe, 360, 455, 1'b0, 4'b0000};
        steps[9] = '{"ball centre", 2'b00, 1'b0, 0, abs_probe, 320, 449, 1'b0, 4'b1100};
        steps[10] = '{"ball corner", 2'b00, 1'b0, 0, abs_probe, 316, 445, 1'b0, 4'b0000};
        steps[11] = '{"empty field", 2'b00, 1'b0, 0, abs_probe, 320, 300, 1'b0, 4'b0000};
        // paddle travel
        steps[12] = '{"right three ticks", 2'b01, 1'b0, 3, abs_probe, 285, 455, 1'b0, 4'b0000};
        steps[13] = '{"right step model", 2'b01, 1'b0, 1, paddle_probe, 0, 455, 1'b1, 4'b0000};
        steps[14] = '{"right edge", 2'b01, 1'b0, 150, abs_probe, 639, 455, 1'b0, 4'b1110};
        steps[15] = '{"right edge held", 2'b01, 1'b0, 4, abs_probe, 559, 455, 1'b0, 4'b0000};
        steps[16] = '{"left edge", 2'b10, 1'b0, 300, abs_probe, 0, 455, 1'b0, 4'b1110};
        steps[17] = '{"left edge end", 2'b10, 1'b0, 0, abs_probe, 80, 455, 1'b0, 4'b0000};
        steps[18] = '{"both buttons", 2'b11, 1'b0, 5, abs_probe, 10, 455, 1'b0, 4'b1110};
        steps[19] = '{"both buttons gap", 2'b11, 1'b0, 0, abs_probe, 9, 455, 1'b0, 4'b0000};
        // launch
        steps[20] = '{"no start", 2'b00, 1'b0, 4, abs_probe, 320, 449, 1'b0, 4'b1100};
        steps[21] = '{"start tick", 2'b00, 1'b1, 1, abs_probe, 320, 449, 1'b0, 4'b1100};
        steps[22] = '{"first step", 2'b00, 1'b0, 1, abs_probe, 316, 447, 1'b0, 4'b1100};
        steps[23] = '{"first step trail", 2'b00, 1'b0, 0, abs_probe, 320, 452, 1'b0, 4'b0000};
        steps[24] = '{"climb model", 2'b00, 1'b0, 20, ball_probe, 4, 4, 1'b1, 4'b0000};
        // brick wall and left wall
        steps[25] = '{"below wall", 2'b00, 1'b0, 244, ball_probe, 4, 4, 1'b1, 4'b0000};
        steps[26] = '{"brick 81 intact", 2'b00, 1'b0, 0, abs_probe, 60, 170, 1'b0, 4'b1001};
        steps[27] = '{"brick hit", 2'b00, 1'b0, 1, abs_probe, 54, 183, 1'b0, 4'b1100};
        steps[28] = '{"brick 81 cleared", 2'b00, 1'b0, 0, abs_probe, 60, 165, 1'b0, 4'b0000};
        steps[29] = '{"brick 82 stays", 2'b00, 1'b0, 0, abs_probe, 100, 170, 1'b0, 4'b1100};
        steps[30] = '{"after brick bounce", 2'b00, 1'b0, 1, abs_probe, 53, 187, 1'b0, 4'b1100};
        steps[31] = '{"left wall", 2'b00, 1'b0, 49, abs_probe, 4, 233, 1'b0, 4'b1100};
        steps[32] = '{"after wall bounce", 2'b00, 1'b0, 1, abs_probe, 5, 234, 1'b0, 4'b1100};
        // miss
        steps[33] = '{"fall model", 2'b00, 1'b0, 100, ball_probe, 4, 4, 1'b1, 4'b0000};
        steps[34] = '{"fall past bottom", 2'b00, 1'b0, 160, abs_probe, 255, 484, 1'b0, 4'b1100};
        steps[35] = '{"frozen", 2'b00, 1'b0, 20, abs_probe, 255, 484, 1'b0, 4'b1100};
        steps[36] = '{"frozen model", 2'b00, 1'b0, 0, ball_probe, 4, 4, 1'b1, 4'b0000};
        steps[37] = '{"paddle after miss", 2'b00, 1'b0, 0, abs_probe, 10, 455, 1'b0, 4'b1110};
    endtask

    ////////////////////
    // drivers
    ////////////////////

    // pixel 0 of line 481 for one cycle, then park
    task automatic issue_tick();
        int waited;
        waited = 0;
        pix_x = 10'd0;
        pix_y = 10'(frame_line);
        do begin
            @(negedge clk);
            waited++;
        end while (!uut.frame_tick && waited < wait_limit);
        if (!uut.frame_tick) begin
            $display("frame strobe did not appear after the tick pixel");
            timeouts++;
        end
        pix_x = 10'(idle_x);
        pix_y = 10'(idle_y);
        // state moves on the edge that ends the strobe
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (uut.frame_tick && waited < wait_limit);
        if (uut.frame_tick) begin
            $display("frame strobe stayed high after the tick pixel");
            timeouts++;
        end
    endtask

    // colour of one pixel, one cycle after it is applied
    task automatic probe_pixel(input int x, input int y, output logic [3:0] got);
        int waited;
        waited = 0;
        pix_x = 10'(x);
        pix_y = 10'(y);
        do begin
            @(negedge clk);
            waited++;
        end while ((uut.pix_x_q != pix_x || uut.pix_y_q != pix_y) && waited < wait_limit);
        if (uut.pix_x_q != pix_x || uut.pix_y_q != pix_y) begin
            $display("probe pixel %0d,%0d never reached the colour stage", x, y);
            timeouts++;
        end
        checks++;
        assert (waited == 1) else begin
            $display("colour for pixel %0d,%0d came %0d cycles late", x, y, waited - 1);
            errors++;
        end
        got = {graph_on, graph_rgb};
    endtask

    task automatic apply_step(input step_t s);
        int x;
        int y;
        logic [3:0] want;
        logic [3:0] got;
        btn = s.btn;
        start = s.start;
        for (int t = 0; t < s.ticks && timeouts == 0; t++) begin
            issue_tick();
            advance_model(s.btn, s.start);
        end
        if (timeouts == 0) begin
            x = s.px;
            y = s.py;
            // probes that follow the moving objects
            if (s.mode == ball_probe) begin
                x = x + m_bx;
                y = y + m_by;
            end else if (s.mode == paddle_probe) begin
                x = x + m_pad;
            end
            want = s.from_model ? expected_pixel(x, y) : s.want;
            probe_pixel(x, y, got);
            checks++;
            assert (got == want) else begin
                $display("Fail %s: expected %b actual %b", s.name, want, got);
                errors++;
            end
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        clk = 1'b0;
        reset = 1'b0;
        btn = 2'b00;
        start = 1'b0;
        pix_x = 10'(idle_x);
        pix_y = 10'(idle_y);
        errors = 0;
        checks = 0;
        timeouts = 0;
        load_steps();
        reset_model();
        // 16 cycles in reset
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < num_steps; i++) begin
            if (timeouts == 0) begin
                apply_step(steps[i]);
            end
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+bench
hw/game_geom_pkg.sv
hw/game_ctrl_pkg.sv
hw/ball_if.sv
hw/playfield_scan.sv
hw/paddle_ctrl.sv
hw/ball_motion.sv
hw/brick_field.sv
hw/pixel_mixer.sv
hw/breakout_top.sv
bench/breakout_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the breakout testbench with verilator and run it
# success only when the pass line shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module breakout_tb -f vlog.f -o breakout_sim &&
./obj_dir/breakout_sim | tee /dev/stderr | grep -q "Done: no errors" &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}
